// File: Bender.yml
package:
  name: esp_link_uart

sources:
  - esp_link_pkg.sv
  - link_fifo.sv
  - uart_tx_serializer.sv
  - uart_rx_deserializer.sv
  - frame_escaper.sv
  - frame_unescaper.sv
  - esp_link_uart.sv
  - target: test
    files:
      - tb_esp_link_uart.sv

// File: esp_link_pkg.sv
package esp_link_pkg;

    ////////////////////////////////////////
    // Framing bytes
    ////////////////////////////////////////
    localparam logic [7:0] SOF_BYTE = 8'h7E;
    localparam logic [7:0] ESC_BYTE = 8'h7D;

    // Applied to the byte that follows ESC_BYTE
    localparam logic [7:0] ESC_XOR  = 8'h20;

    ////////////////////////////////////////
    // Serial timing and FIFO sizing
    ////////////////////////////////////////
    localparam int CLKS_PER_BIT   = 16;
    localparam int TX_FIFO_DEPTH  = 16;
    localparam int RX_FIFO_DEPTH  = 16;

    // Fill level that raises request-to-send
    localparam int RX_ALMOST_FULL = 12;

    // Host word, sof set means start of frame and data is ignored
    typedef struct packed {
        logic       sof;
        logic [7:0] data;
    } host_word_t;

    // Escaper states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_LOAD,
        TX_ESCAPED
    } tx_state_e;

    // Deserializer states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// File: esp_link_trace.txt
# T: host word (hex, bit 8 = SOF), byte count, expected esp_tx bytes (hex)
# R: esp_rx byte (hex), stop bit, word count, expected host word (hex)
# C: esp_cts high cycles  F: bytes into the receive FIFO unread  X: end of test
T 100 1 7E 00
T 041 1 41 00
T 000 1 00 00
T 0FF 1 FF 00
X
T 100 1 7E 00
T 07D 2 7D 5D
T 07E 2 7D 5E
T 17E 1 7E 00
T 05E 1 5E 00
X
R 7E 1 1 100
R 31 1 1 031
R 7D 1 0 000
R 5E 1 1 07E
R 7D 1 0 000
R 5D 1 1 07D
R 7D 1 0 000
R 7E 1 1 100
R 42 1 1 042
X
R 55 0 0 000
R 66 1 1 066
X
C 400
T 100 1 7E 00
T 07D 2 7D 5D
T 033 1 33 00
X
F 17
X

// File: esp_link_uart.f
esp_link_pkg.sv
link_fifo.sv
uart_tx_serializer.sv
uart_rx_deserializer.sv
frame_escaper.sv
frame_unescaper.sv
esp_link_uart.sv
tb_esp_link_uart.sv

// File: esp_link_uart.sv
`timescale 1ns/10ps

module esp_link_uart (
    input  logic       clk,
    input  logic       reset,

    // Host transmit queue, bit 8 marks start of frame
    input  logic [8:0] txfifo_data,
    input  logic       txfifo_wr,
    output logic       txfifo_full,

    // Host receive queue
    output logic [8:0] rxfifo_data,
    input  logic       rxfifo_rd,
    output logic       rxfifo_empty,
    output logic       rxfifo_overflow,
    output logic       rx_framing_error,

    // Co-processor serial pins
    output logic       esp_tx,
    input  logic       esp_rx,
    output logic       esp_rts,
    input  logic       esp_cts
);
    import esp_link_pkg::*;

    host_word_t tx_head;
    logic       tx_empty;
    logic       tx_pop;
    logic       tx_busy;
    logic       tx_start;
    logic [7:0] tx_byte;

    host_word_t rx_head;
    host_word_t rx_word;
    logic       rx_word_wr;
    logic       rx_full;
    logic [7:0] rx_byte;
    logic       rx_valid;

    assign rxfifo_data = rx_head;

    ////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////
    link_fifo #(
        .DEPTH       (TX_FIFO_DEPTH),
        .ALMOST_FULL (TX_FIFO_DEPTH)
    ) tx_fifo (
        .clk         (clk),
        .reset       (reset),
        .wr_data     (txfifo_data),
        .wr_en       (txfifo_wr),
        .rd_data     (tx_head),
        .rd_en       (tx_pop),
        .empty       (tx_empty),
        .full        (txfifo_full),
        .almost_full ()
    );

    frame_escaper u_escaper (
        .clk        (clk),
        .reset      (reset),
        .cts        (esp_cts),
        .fifo_word  (tx_head),
        .fifo_empty (tx_empty),
        .fifo_rd    (tx_pop),
        .tx_busy    (tx_busy),
        .tx_data    (tx_byte),
        .tx_start   (tx_start)
    );

    uart_tx_serializer u_serializer (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_byte),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .txd      (esp_tx)
    );

    ////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////
    uart_rx_deserializer u_deserializer (
        .clk           (clk),
        .reset         (reset),
        .rxd           (esp_rx),
        .rx_data       (rx_byte),
        .rx_valid      (rx_valid),
        .framing_error (rx_framing_error)
    );

    frame_unescaper u_unescaper (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_byte),
        .rx_valid  (rx_valid),
        .fifo_full (rx_full),
        .word      (rx_word),
        .word_wr   (rx_word_wr),
        .overflow  (rxfifo_overflow)
    );

    // Almost-full drives request-to-send directly
    link_fifo #(
        .DEPTH       (RX_FIFO_DEPTH),
        .ALMOST_FULL (RX_ALMOST_FULL)
    ) rx_fifo (
        .clk         (clk),
        .reset       (reset),
        .wr_data     (rx_word),
        .wr_en       (rx_word_wr),
        .rd_data     (rx_head),
        .rd_en       (rxfifo_rd),
        .empty       (rxfifo_empty),
        .full        (rx_full),
        .almost_full (esp_rts)
    );

endmodule

// File: frame_escaper.sv
`timescale 1ns/10ps

module frame_escaper (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cts,
    input  esp_link_pkg::host_word_t fifo_word,
    input  logic                     fifo_empty,
    output logic                     fifo_rd,
    input  logic                     tx_busy,
    output logic [7:0]               tx_data,
    output logic                     tx_start
);
    import esp_link_pkg::*;

    tx_state_e  state;
    host_word_t held_word;
    logic [1:0] cts_sync;
    logic       needs_escape;
    logic       second_ready;

    // Clear-to-send is active low, paused until sampled after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cts_sync <= 2'b11;
        end else begin
            cts_sync <= {cts_sync[0], cts};
        end
    end

    // Only checked before a pop, an escape pair is never split
    assign fifo_rd = (state == TX_IDLE) && !tx_start && !cts_sync[1] &&
                     !fifo_empty && !tx_busy;

    assign needs_escape = !held_word.sof &&
                          (held_word.data == ESC_BYTE || held_word.data == SOF_BYTE);

    // Previous byte accepted and finished
    assign second_ready = (state == TX_ESCAPED) && !tx_start && !tx_busy;

    ////////////////////////////////////////
    // Escape FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= TX_IDLE;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;

            case (state)
                TX_IDLE: begin
                    if (fifo_rd) begin
                        state <= TX_LOAD;
                    end
                end

                TX_LOAD: begin
                    tx_start <= 1'b1;
                    state    <= needs_escape ? TX_ESCAPED : TX_IDLE;
                end

                TX_ESCAPED: begin
                    if (second_ready) begin
                        tx_start <= 1'b1;
                        state    <= TX_IDLE;
                    end
                end

                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            held_word <= fifo_word;
        end
        if (state == TX_LOAD) begin
            if (held_word.sof) begin
                tx_data <= SOF_BYTE;
            end else begin
                tx_data <= needs_escape ? ESC_BYTE : held_word.data;
            end
        end else if (second_ready) begin
            tx_data <= held_word.data ^ ESC_XOR;
        end
    end

endmodule

// File: frame_unescaper.sv
`timescale 1ns/10ps

module frame_unescaper (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               rx_data,
    input  logic                     rx_valid,
    input  logic                     fifo_full,
    output esp_link_pkg::host_word_t word,
    output logic                     word_wr,
    output logic                     overflow
);
    import esp_link_pkg::*;

    logic escape;
    logic is_sof;
    logic is_esc;
    logic makes_word;

    assign is_sof     = (rx_data == SOF_BYTE);
    assign is_esc     = (rx_data == ESC_BYTE);
    assign makes_word = rx_valid && !is_esc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            escape   <= 1'b0;
            word_wr  <= 1'b0;
            overflow <= 1'b0;
        end else begin
            // Word is dropped here when the FIFO is full
            word_wr  <= makes_word && !fifo_full;
            overflow <= makes_word && fifo_full;
            if (rx_valid) begin
                escape <= is_esc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (makes_word) begin
            if (is_sof) begin
                word <= '{sof: 1'b1, data: 8'h00};
            end else begin
                word <= '{sof: 1'b0, data: rx_data ^ (escape ? ESC_XOR : 8'h00)};
            end
        end
    end

endmodule

// File: link_fifo.sv
`timescale 1ns/10ps

module link_fifo #(
    parameter int DEPTH       = esp_link_pkg::TX_FIFO_DEPTH,
    parameter int ALMOST_FULL = esp_link_pkg::RX_ALMOST_FULL
) (
    input  logic                    clk,
    input  logic                    reset,
    input  esp_link_pkg::host_word_t wr_data,
    input  logic                    wr_en,
    output esp_link_pkg::host_word_t rd_data,
    input  logic                    rd_en,
    output logic                    empty,
    output logic                    full,
    output logic                    almost_full
);
    import esp_link_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    host_word_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic          wr_ok;
    logic          rd_ok;

    // Requests that can actually be served
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    always_comb begin
        count_next = count;
        if (wr_ok && !rd_ok) begin
            count_next = count + CW'(1);
        end else if (rd_ok && !wr_ok) begin
            count_next = count - CW'(1);
        end
    end

    // Show-ahead, head word always on the output
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own for power-of-two depths
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            empty       <= 1'b1;
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            count       <= count_next;
            empty       <= (count_next == '0);
            full        <= (count_next == CW'(DEPTH));
            almost_full <= (count_next >= CW'(ALMOST_FULL));
        end
    end

endmodule

// File: tb_esp_link_uart.sv
`timescale 1ns/10ps

module tb_esp_link_uart;
    import esp_link_pkg::*;

    logic       clk;
    logic       reset;
    logic [8:0] txfifo_data;
    logic       txfifo_wr;
    logic       txfifo_full;
    logic [8:0] rxfifo_data;
    logic       rxfifo_rd;
    logic       rxfifo_empty;
    logic       rxfifo_overflow;
    logic       rx_framing_error;
    logic       esp_tx;
    logic       esp_rx;
    logic       esp_rts;
    logic       esp_cts;

    // Current test group as read from the trace
    host_word_t tx_words[$];
    logic [7:0] tx_bytes[$];
    logic [7:0] rx_bytes[$];
    bit         rx_stops[$];
    host_word_t rx_words[$];
    int         cts_hold = 0;
    int         fill_count = 0;

    string      recs[$];
    int         test_errors = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         framing_seen = 0;
    int         overflow_seen = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    esp_link_uart u_dut (
        .clk              (clk),
        .reset            (reset),
        .txfifo_data      (txfifo_data),
        .txfifo_wr        (txfifo_wr),
        .txfifo_full      (txfifo_full),
        .rxfifo_data      (rxfifo_data),
        .rxfifo_rd        (rxfifo_rd),
        .rxfifo_empty     (rxfifo_empty),
        .rxfifo_overflow  (rxfifo_overflow),
        .rx_framing_error (rx_framing_error),
        .esp_tx           (esp_tx),
        .esp_rx           (esp_rx),
        .esp_rts          (esp_rts),
        .esp_cts          (esp_cts)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One-cycle pulses are caught at the falling edge
    always @(negedge clk) begin
        if (rx_framing_error) framing_seen++;
        if (rxfifo_overflow) overflow_seen++;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_word(input host_word_t got, input host_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got 0x%03h expected 0x%03h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_line_byte(input logic [7:0] got, input logic [7:0] exp,
                                   input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %0b expected %0b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_missing(input string what);
        $display("Missing at %0t: %s", $time, what);
        test_errors++;
    endtask

    task automatic check_pulses(input int seen, input int exp, input string name);
        if (seen < exp) begin
            report_missing($sformatf("%0d %s pulse(s) expected, %0d seen", exp, name, seen));
        end else if (seen > exp) begin
            check_flag(1'b1, 1'b0, $sformatf("extra %s pulse", name));
        end
    endtask

    ////////////////////////////////////////
    // Host side and line tasks
    ////////////////////////////////////////
    task automatic write_host_words();
        int i;
        for (i = 0; i < tx_words.size(); i++) begin
            @(posedge clk);
            #2;
            // Trace groups stay below the transmit FIFO depth
            check_flag(txfifo_full, 1'b0, "txfifo_full before a host write");
            txfifo_data = tx_words[i];
            txfifo_wr   = 1'b1;
        end
        @(posedge clk);
        #2;
        txfifo_wr = 1'b0;
    endtask

    task automatic pop_word(output host_word_t w, output bit got);
        repeat ($urandom % 4) @(posedge clk);
        @(negedge clk);
        got = !rxfifo_empty;
        w   = rxfifo_data;
        if (got) begin
            @(posedge clk);
            #2 rxfifo_rd = 1'b1;
            @(posedge clk);
            #2 rxfifo_rd = 1'b0;
        end
    endtask

    task automatic send_line_byte(input logic [7:0] data, input bit stop);
        logic [9:0] frame;
        int         gap;
        int         i;
        frame = {stop, data, 1'b0};
        // At least one idle bit between bytes
        gap = CLKS_PER_BIT + ($urandom % 24);
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            #2 esp_rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        #2 esp_rx = 1'b1;
        repeat (gap) @(posedge clk);
    endtask

    // Returns at the middle of the stop bit
    task automatic grab_line_byte(input int max_wait, output logic [7:0] data,
                                  output bit found);
        int waited;
        int i;
        waited = 0;
        found  = 1'b0;
        data   = '0;
        @(negedge clk);
        while (esp_tx !== 1'b0 && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        if (esp_tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            found = (esp_tx === 1'b0);
        end
        if (found) begin
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[i] = esp_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_flag(esp_tx, 1'b1, "esp_tx stop bit");
        end
    endtask

    ////////////////////////////////////////
    // Test kinds
    ////////////////////////////////////////
    task automatic expect_line_bytes();
        logic [7:0] data;
        bit         found;
        int         i;
        found = 1'b1;
        for (i = 0; i < tx_bytes.size() && found; i++) begin
            grab_line_byte(40 * CLKS_PER_BIT, data, found);
            if (found) begin
                check_line_byte(data, tx_bytes[i], $sformatf("esp_tx byte %0d", i));
            end else begin
                report_missing($sformatf("byte 0x%02h never started on esp_tx", tx_bytes[i]));
            end
        end
        // Nothing may follow the expected bytes
        grab_line_byte(4 * CLKS_PER_BIT, data, found);
        if (found) check_flag(1'b1, 1'b0, "extra byte on esp_tx");
    endtask

    task automatic run_tx_test();
        bit moved;
        moved = 1'b0;
        if (cts_hold > 0) begin
            @(posedge clk);
            #2 esp_cts = 1'b1;
            repeat (3) @(posedge clk);
            write_host_words();
            repeat (cts_hold) begin
                @(negedge clk);
                if (esp_tx !== 1'b1) moved = 1'b1;
            end
            check_flag(moved, 1'b0, "start bit on esp_tx while esp_cts high");
            @(posedge clk);
            #2 esp_cts = 1'b0;
        end
        fork
            begin
                if (cts_hold == 0) write_host_words();
            end
            expect_line_bytes();
        join
    endtask

    task automatic run_rx_test();
        int         i;
        int         exp_framing;
        int         framing_start;
        int         overflow_start;
        host_word_t w;
        bit         got;
        exp_framing    = 0;
        framing_start  = framing_seen;
        overflow_start = overflow_seen;
        for (i = 0; i < rx_bytes.size(); i++) begin
            send_line_byte(rx_bytes[i], rx_stops[i]);
            if (!rx_stops[i]) exp_framing++;
        end
        for (i = 0; i < rx_words.size(); i++) begin
            pop_word(w, got);
            if (got) begin
                check_word(w, rx_words[i], $sformatf("rxfifo_data word %0d", i));
            end else begin
                report_missing($sformatf("word 0x%03h, receive FIFO empty", rx_words[i]));
            end
        end
        @(negedge clk);
        check_flag(rxfifo_empty, 1'b1, "rxfifo_empty after the expected words");
        check_pulses(framing_seen - framing_start, exp_framing, "rx_framing_error");
        check_pulses(overflow_seen - overflow_start, 0, "rxfifo_overflow");
    endtask

    task automatic run_fill_test();
        int         i;
        int         stored;
        int         overflow_start;
        host_word_t w;
        host_word_t exp;
        bit         got;
        stored         = 0;
        overflow_start = overflow_seen;
        for (i = 0; i < fill_count; i++) begin
            send_line_byte(8'h40 + i[7:0], 1'b1);
            stored = (i + 1 < RX_FIFO_DEPTH) ? i + 1 : RX_FIFO_DEPTH;
            @(negedge clk);
            check_flag(esp_rts, stored >= RX_ALMOST_FULL,
                       $sformatf("esp_rts with %0d words stored", stored));
        end
        check_pulses(overflow_seen - overflow_start, fill_count - stored, "rxfifo_overflow");
        for (i = 0; i < stored; i++) begin
            pop_word(w, got);
            exp = '{sof: 1'b0, data: 8'h40 + i[7:0]};
            if (got) begin
                check_word(w, exp, $sformatf("fill word %0d", i));
            end else begin
                report_missing($sformatf("fill word %0d, receive FIFO empty", i));
            end
        end
        @(negedge clk);
        check_flag(rxfifo_empty, 1'b1, "rxfifo_empty after reading back");
        check_flag(esp_rts, 1'b0, "esp_rts after reading back");
    endtask

    task automatic run_test(input int num);
        string kind;
        test_errors = 0;
        if (fill_count > 0) begin
            kind = "receive fill";
            run_fill_test();
        end else if (rx_bytes.size() > 0) begin
            kind = "receive decode";
            run_rx_test();
        end else begin
            kind = (cts_hold > 0) ? "clear-to-send hold" : "transmit escape";
            run_tx_test();
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %0d (%s): pass", num, kind);
        end else begin
            fail_count++;
            $display("Test %0d (%s): %0d error(s)", num, kind, test_errors);
        end
        tx_words.delete();
        tx_bytes.delete();
        rx_bytes.delete();
        rx_stops.delete();
        rx_words.delete();
        cts_hold   = 0;
        fill_count = 0;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int         fd;
        int         total_bytes;
        int         test_num;
        int         n;
        int         stop;
        byte        tag;
        string      line;
        string      rest;
        logic [8:0] wv;
        logic [7:0] b0;
        logic [7:0] b1;
        reset       = 1'b1;
        txfifo_data = '0;
        txfifo_wr   = 1'b0;
        rxfifo_rd   = 1'b0;
        esp_rx      = 1'b1;
        esp_cts     = 1'b0;
        total_bytes = 0;
        test_num    = 1;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(78));

        fd = $fopen("esp_link_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file esp_link_trace.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    recs.push_back(line);
                end
            end
            $fclose(fd);
        end

        // Byte count sets the run limit
        foreach (recs[k]) begin
            tag  = recs[k].getc(0);
            rest = recs[k].substr(1, recs[k].len() - 1);
            if (tag == "T") begin
                void'($sscanf(rest, "%h %d", wv, n));
                total_bytes += n;
            end else if (tag == "R") begin
                total_bytes += 1;
            end else if (tag == "F") begin
                void'($sscanf(rest, "%d", n));
                total_bytes += n;
            end
        end
        cycle_limit = total_bytes * 10 * CLKS_PER_BIT * 3 + 2000;

        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        repeat (4) @(posedge clk);

        foreach (recs[k]) begin
            tag  = recs[k].getc(0);
            rest = recs[k].substr(1, recs[k].len() - 1);
            case (tag)
                "T": begin
                    void'($sscanf(rest, "%h %d %h %h", wv, n, b0, b1));
                    tx_words.push_back(host_word_t'(wv));
                    tx_bytes.push_back(b0);
                    if (n > 1) tx_bytes.push_back(b1);
                end
                "R": begin
                    void'($sscanf(rest, "%h %d %d %h", b0, stop, n, wv));
                    rx_bytes.push_back(b0);
                    rx_stops.push_back(stop != 0);
                    if (n > 0) rx_words.push_back(host_word_t'(wv));
                end
                "C": void'($sscanf(rest, "%d", cts_hold));
                "F": void'($sscanf(rest, "%d", fill_count));
                "X": begin
                    run_test(test_num);
                    test_num++;
                end
                default: $display("Skipping unknown trace record: %s", recs[k]);
            endcase
        end

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: uart_rx_deserializer.sv
`timescale 1ns/10ps

module uart_rx_deserializer (
    input  logic       clk,
    input  logic       reset,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       framing_error
);
    import esp_link_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

    rx_state_e        state;
    logic [1:0]       rxd_sync;
    logic             rxd_s;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic             sample_data;

    assign rxd_s       = rxd_sync[1];
    assign sample_data = (state == RX_DATA) && (clk_cnt == BIT_END);

    ////////////////////////////////////////
    // Line synchronizer
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    ////////////////////////////////////////
    // Bit timing FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= RX_IDLE;
            clk_cnt       <= '0;
            bit_cnt       <= '0;
            rx_valid      <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            rx_valid      <= 1'b0;
            framing_error <= 1'b0;
            clk_cnt       <= clk_cnt + CNT_W'(1);

            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_s) begin
                        state <= RX_START;
                    end
                end

                RX_START: begin
                    // Confirm start bit at its middle, else a glitch
                    if (clk_cnt == HALF_END) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA;
                    end
                end

                RX_DATA: begin
                    if (clk_cnt == BIT_END) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end

                RX_STOP: begin
                    if (clk_cnt == BIT_END) begin
                        rx_valid      <= rxd_s;
                        framing_error <= !rxd_s;
                        state         <= RX_IDLE;
                    end
                end

                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (sample_data) begin
            rx_data <= {rxd_s, rx_data[7:1]};
        end
    end

endmodule

// File: uart_tx_serializer.sv
`timescale 1ns/10ps

module uart_tx_serializer (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       txd
);
    import esp_link_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       shift_reg;

    // Bit 0 of the shift register is the line, all ones when idle
    assign txd = shift_reg[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_busy   <= 1'b0;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            shift_reg <= '1;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Stop bit, data LSB first, start bit
                shift_reg <= {1'b1, tx_data, 1'b0};
                tx_busy   <= 1'b1;
                clk_cnt   <= '0;
                bit_cnt   <= '0;
            end
        end else if (clk_cnt == BIT_END) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // End of stop bit
                tx_busy <= 1'b0;
            end else begin
                bit_cnt   <= bit_cnt + 4'd1;
                shift_reg <= {1'b1, shift_reg[9:1]};
            end
        end else begin
            clk_cnt <= clk_cnt + CNT_W'(1);
        end
    end

endmodule
